//--- vlog.f
hw/cpu_types_pkg.sv
hw/exec_ctrl_pkg.sv
hw/reg_file.sv
hw/operand_select.sv
hw/alu.sv
hw/exec_ctrl.sv
hw/exec_unit_top.sv
dv/exec_unit_assertions.sv
dv/exec_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= exec_unit_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
RUN_FLAGS ?= +verilator+error+limit+1000
LOG       ?= run.log
PASS_MSG  := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/exec_unit_tb.sv
// Testbench for the execute unit: directed and random commands checked against a register model
`timescale 1ns/100ps

module exec_unit_tb;
  import cpu_types_pkg::*;
  import exec_ctrl_pkg::*;

  localparam int NUM_DIRECTED = 46;  // 32 register reads plus 14 directed operations
  localparam int NUM_RANDOM   = 200;
  localparam int CYCLE_LIMIT  = (NUM_DIRECTED + NUM_RANDOM) * 4 + 100;
  localparam int unsigned SEED = 32'hf520_85ab;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       cmd_valid;
  exec_cmd_t  cmd;
  logic       busy;
  logic       done;
  word_t      result;
  alu_flags_t flags;

  word_t model_regs [NUM_REGS];  // Shadow of the register file
  int    data_errors = 0;
  int    cycles = 0;

  exec_unit_top uut (
    .clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd(cmd),
    .busy(busy), .done(done), .result(result), .flags(flags)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the command sequence did not finish within %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic compare_word(input string name, input word_t exp, input word_t act);
    assert (act === exp) else begin
      $display("MISMATCH %s: expected %h, got %h", name, exp, act);
      data_errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("MISMATCH %s: expected %h, got %h", name, exp, act);
      data_errors++;
    end
  endtask

  function automatic exec_cmd_t make_cmd(alu_op_t op, reg_addr_t rs, reg_addr_t rt,
                                         reg_addr_t rd, imm_t imm, b_sel_t b_sel);
    return '{op: op, rs: rs, rt: rt, rd: rd, imm: imm, b_sel: b_sel};
  endfunction

  function automatic exec_cmd_t random_cmd();
    return make_cmd(alu_op_t'($urandom_range(4, 0)), reg_addr_t'($urandom),
                    reg_addr_t'($urandom), reg_addr_t'($urandom),
                    imm_t'($urandom), b_sel_t'($urandom));
  endfunction

  // Expected result and flags from the operation rules and the shadow registers
  task automatic compute_expected(input exec_cmd_t c, output word_t y, output alu_flags_t f);
    word_t  a;
    word_t  b;
    longint s_sum;
    longint s_dif;
    a = model_regs[c.rs];
    case (c.b_sel)
      B_IMM_SEXT: b = {{16{c.imm[15]}}, c.imm};
      B_IMM_HI:   b = {c.imm, 16'h0000};
      default:    b = model_regs[c.rt];  // B_REG and the spare code 3
    endcase
    s_sum = longint'($signed(a)) + longint'($signed(b));
    s_dif = longint'($signed(a)) - longint'($signed(b));
    f = '0;
    case (c.op)
      ALU_ADD: begin
        y          = a + b;
        f.carry    = ({32'h0, a} + {32'h0, b}) > 64'hffff_ffff;
        f.overflow = (s_sum > 64'sd2147483647) || (s_sum < -64'sd2147483648);
      end
      ALU_SUB: begin
        y          = a - b;
        f.carry    = (a >= b);  // No borrow
        f.overflow = (s_dif > 64'sd2147483647) || (s_dif < -64'sd2147483648);
      end
      ALU_AND: y = a & b;
      ALU_OR:  y = a | b;
      default: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
    f.zero = (y == '0);
  endtask

  // Issue one command at a falling edge, optionally strobe again while busy, then check
  task automatic run_cmd(input exec_cmd_t c, input bit stray);
    word_t      exp_y;
    alu_flags_t exp_f;
    compute_expected(c, exp_y, exp_f);
    cmd_valid = 1'b1;
    cmd       = c;
    @(negedge clk);
    if (stray) begin
      cmd = random_cmd();  // Must be ignored
    end else begin
      cmd_valid = 1'b0;
    end
    @(negedge clk);
    cmd_valid = 1'b0;
    while (done !== 1'b1) @(negedge clk);
    compare_word("result", exp_y, result);
    compare_bit("flags.zero", exp_f.zero, flags.zero);
    compare_bit("flags.carry", exp_f.carry, flags.carry);
    compare_bit("flags.overflow", exp_f.overflow, flags.overflow);
    if (c.rd != '0) model_regs[c.rd] = exp_y;
  endtask

  initial begin
    int total;
    void'($urandom(SEED));
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    compare_bit("busy", 1'b0, busy);
    compare_bit("done", 1'b0, done);

    // Every register reads zero after reset
    for (int i = 0; i < NUM_REGS; i++) begin
      run_cmd(make_cmd(ALU_OR, reg_addr_t'(i), 5'd0, 5'd0, 16'h0000, B_IMM_SEXT), 1'b0);
      compare_bit("flags.zero", 1'b1, flags.zero);
    end

    run_cmd(make_cmd(ALU_ADD, 5'd0, 5'd0, 5'd1, 16'h7fff, B_IMM_SEXT), 1'b0);
    run_cmd(make_cmd(ALU_ADD, 5'd0, 5'd0, 5'd2, 16'h8000, B_IMM_SEXT), 1'b1);  // Negative imm
    run_cmd(make_cmd(ALU_OR,  5'd0, 5'd0, 5'd3, 16'h8000, B_IMM_HI), 1'b0);
    run_cmd(make_cmd(ALU_ADD, 5'd3, 5'd3, 5'd4, 16'h0000, B_REG), 1'b0);  // Carry and overflow
    run_cmd(make_cmd(ALU_SUB, 5'd1, 5'd2, 5'd5, 16'h0000, B_REG), 1'b1);  // Borrow
    run_cmd(make_cmd(ALU_SUB, 5'd3, 5'd1, 5'd6, 16'h0000, B_REG), 1'b0);  // Signed overflow
    run_cmd(make_cmd(ALU_SLT, 5'd2, 5'd1, 5'd7, 16'h0000, B_REG), 1'b0);
    run_cmd(make_cmd(ALU_SLT, 5'd1, 5'd2, 5'd8, 16'h0000, B_REG), 1'b0);
    run_cmd(make_cmd(ALU_AND, 5'd2, 5'd0, 5'd9, 16'hffff, B_IMM_HI), 1'b0);
    run_cmd(make_cmd(ALU_SUB, 5'd1, 5'd1, 5'd11, 16'h0000, B_REG), 1'b0);
    run_cmd(make_cmd(ALU_ADD, 5'd1, 5'd0, 5'd0, 16'h0001, B_IMM_SEXT), 1'b0);  // Write to r0
    run_cmd(make_cmd(ALU_OR,  5'd0, 5'd0, 5'd12, 16'h0000, B_IMM_SEXT), 1'b0);
    compare_word("r0 readback", 32'h0, result);
    run_cmd(make_cmd(ALU_OR,  5'd1, 5'd9, 5'd13, 16'h0000, 2'd3), 1'b0);  // Spare select code
    run_cmd(make_cmd(ALU_ADD, 5'd4, 5'd5, 5'd14, 16'h0000, B_REG), 1'b0);

    // Random commands, mostly back to back
    for (int n = 0; n < NUM_RANDOM; n++) begin
      if ($urandom_range(3, 0) == 0) repeat ($urandom_range(2, 1)) @(negedge clk);
      run_cmd(random_cmd(), $urandom_range(3, 0) == 0);
    end

    repeat (3) @(negedge clk);  // Let the last concurrent checks settle
    total = data_errors + uut.u_assert.fail_count;
    $display("Error counts: data %0d, assertion %0d", data_errors, uut.u_assert.fail_count);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- dv/exec_unit_assertions.sv
// Concurrent checks on command timing and ALU flags bound into the execute unit top level
`timescale 1ns/100ps

module exec_unit_assertions (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       cmd_valid,
  input logic                       busy,
  input logic                       done,
  input cpu_types_pkg::word_t       result,
  input exec_ctrl_pkg::alu_flags_t  flags,
  input cpu_types_pkg::alu_op_t     op,
  input exec_ctrl_pkg::alu_flags_t  alu_flags
);
  import cpu_types_pkg::*;
  import exec_ctrl_pkg::*;

  int fail_count = 0;  // Number of failed checks

  // A strobe while idle starts exactly one execute cycle
  a_accept_to_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_valid && !busy) |=> busy)
    else begin
      fail_count++;
      $error("accepted command did not raise busy");
    end

  a_busy_to_done: assert property (@(posedge clk) disable iff (!rst_n)
    busy |=> (!busy && done))
    else begin
      fail_count++;
      $error("busy did not end in a done pulse");
    end

  // Strobes seen while busy must not start anything
  a_busy_source: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> ($past(cmd_valid) && !$past(busy)))
    else begin
      fail_count++;
      $error("busy rose without an accepted command");
    end

  a_done_source: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> $past(busy))
    else begin
      fail_count++;
      $error("done pulsed without an execute cycle");
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done)
    else begin
      fail_count++;
      $error("done stayed high for more than one cycle");
    end

  // Flag rules
  a_zero_result: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> (flags.zero == (result == '0)))
    else begin
      fail_count++;
      $error("registered zero flag disagrees with result");
    end

  a_logic_flags: assert property (@(posedge clk) disable iff (!rst_n)
    (busy && (op != ALU_ADD) && (op != ALU_SUB)) |-> (!alu_flags.carry && !alu_flags.overflow))
    else begin
      fail_count++;
      $error("carry or overflow set outside add and sub");
    end

endmodule

bind exec_unit_top exec_unit_assertions u_assert (
  .clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .busy(busy), .done(done),
  .result(result), .flags(flags), .op(op), .alu_flags(alu_flags)
);

//--- hw/exec_unit_top.sv
// Execute unit top level: control FSM with register file, operand select and ALU
`timescale 1ns/100ps

module exec_unit_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cmd_valid,
  input  exec_ctrl_pkg::exec_cmd_t   cmd,
  output logic                       busy,
  output logic                       done,
  output cpu_types_pkg::word_t       result,
  output exec_ctrl_pkg::alu_flags_t  flags
);
  import cpu_types_pkg::*;
  import exec_ctrl_pkg::*;

  reg_addr_t  rs_addr;
  reg_addr_t  rt_addr;
  word_t      rs_data;
  word_t      rt_data;
  imm_t       imm;
  b_sel_t     b_sel;
  alu_op_t    op;
  word_t      b_operand;
  word_t      alu_result;
  alu_flags_t alu_flags;
  logic       wr_en;
  reg_addr_t  wr_addr;
  word_t      wr_data;

  exec_ctrl u_ctrl (
    .clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd(cmd),
    .busy(busy), .done(done),
    .rs_addr(rs_addr), .rt_addr(rt_addr), .imm(imm), .b_sel(b_sel), .op(op),
    .alu_result(alu_result), .alu_flags(alu_flags),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .result(result), .flags(flags)
  );

  reg_file u_regs (
    .clk(clk), .rst_n(rst_n),
    .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
  );

  operand_select u_bsel (
    .rt_data(rt_data), .imm(imm), .b_sel(b_sel), .b_operand(b_operand)
  );

  alu u_alu (
    .a(rs_data), .b(b_operand), .op(op), .y(alu_result), .flags(alu_flags)
  );

endmodule

//--- hw/exec_ctrl.sv
// Execute control FSM: captures a command, runs read, execute and write-back, registers the result
`timescale 1ns/100ps

module exec_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cmd_valid,
  input  exec_ctrl_pkg::exec_cmd_t   cmd,
  output logic                       busy,
  output logic                       done,
  output cpu_types_pkg::reg_addr_t   rs_addr,
  output cpu_types_pkg::reg_addr_t   rt_addr,
  output cpu_types_pkg::imm_t        imm,
  output cpu_types_pkg::b_sel_t      b_sel,
  output cpu_types_pkg::alu_op_t     op,
  input  cpu_types_pkg::word_t       alu_result,
  input  exec_ctrl_pkg::alu_flags_t  alu_flags,
  output logic                       wr_en,
  output cpu_types_pkg::reg_addr_t   wr_addr,
  output cpu_types_pkg::word_t       wr_data,
  output cpu_types_pkg::word_t       result,
  output exec_ctrl_pkg::alu_flags_t  flags
);
  import exec_ctrl_pkg::*;

  exec_state_t state;
  exec_state_t state_nxt;
  exec_cmd_t   cmd_q;     // Command held for the execute cycle
  logic        accept;

  // Strobes seen while busy are dropped here
  assign accept = cmd_valid && (state == ST_IDLE);

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: if (accept) state_nxt = ST_EXEC;
      ST_EXEC: state_nxt = ST_IDLE;  // Single execute cycle
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= ST_IDLE;
      done   <= 1'b0;
      result <= '0;
      flags  <= '0;
    end else begin
      state <= state_nxt;
      done  <= (state == ST_EXEC);
      if (state == ST_EXEC) begin
        result <= alu_result;
        flags  <= alu_flags;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) cmd_q <= cmd;
  end

  assign busy = (state == ST_EXEC);

  // Command fields to the datapath
  assign rs_addr = cmd_q.rs;
  assign rt_addr = cmd_q.rt;
  assign imm     = cmd_q.imm;
  assign b_sel   = cmd_q.b_sel;
  assign op      = cmd_q.op;

  // Write-back, the register file drops writes to r0
  assign wr_en   = (state == ST_EXEC);
  assign wr_addr = cmd_q.rd;
  assign wr_data = alu_result;

endmodule

//--- hw/alu.sv
// 32-bit ALU with add, sub, and, or and slt through a 5:1 result select, plus flags
`timescale 1ns/100ps

module alu (
  input  cpu_types_pkg::word_t       a,
  input  cpu_types_pkg::word_t       b,
  input  cpu_types_pkg::alu_op_t     op,
  output cpu_types_pkg::word_t       y,
  output exec_ctrl_pkg::alu_flags_t  flags
);
  import cpu_types_pkg::*;

  logic [WORD_W:0] sum;   // Carry out in the top bit
  logic [WORD_W:0] diff;  // No-borrow carry in the top bit
  word_t           and_w;
  word_t           or_w;
  word_t           slt_w;
  logic            ovf_add;
  logic            ovf_sub;

  word_t           pair0;   // add or sub
  word_t           pair1;   // and or or
  word_t           arith;   // Output of the two-input stage

  // Subtract as a + ~b + 1 so the carry reads as no-borrow
  assign sum  = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} + {1'b0, ~b} + {{WORD_W{1'b0}}, 1'b1};

  assign and_w = a & b;
  assign or_w  = a | b;

  // Signed overflow from the operand and result signs
  assign ovf_add = (a[WORD_W-1] == b[WORD_W-1]) && (sum[WORD_W-1] != a[WORD_W-1]);
  assign ovf_sub = (a[WORD_W-1] != b[WORD_W-1]) && (diff[WORD_W-1] != a[WORD_W-1]);

  // Signed less-than is the difference sign corrected by overflow
  assign slt_w = {{(WORD_W - 1){1'b0}}, diff[WORD_W-1] ^ ovf_sub};

  // 5:1 select, two 2:1 pairs on op[0], then op[1], then slt on op[2]
  assign pair0 = op[0] ? diff[WORD_W-1:0] : sum[WORD_W-1:0];
  assign pair1 = op[0] ? or_w : and_w;
  assign arith = op[1] ? pair1 : pair0;
  assign y     = op[2] ? slt_w : arith;

  assign flags = '{
    zero:     (y == '0),
    carry:    (op == ALU_ADD) ? sum[WORD_W] :
              (op == ALU_SUB) ? diff[WORD_W] : 1'b0,
    overflow: (op == ALU_ADD) ? ovf_add :
              (op == ALU_SUB) ? ovf_sub : 1'b0
  };

endmodule

//--- hw/operand_select.sv
// B operand path: extends the immediate and picks one of three word sources
`timescale 1ns/100ps

module operand_select (
  input  cpu_types_pkg::word_t  rt_data,
  input  cpu_types_pkg::imm_t   imm,
  input  cpu_types_pkg::b_sel_t b_sel,
  output cpu_types_pkg::word_t  b_operand
);
  import cpu_types_pkg::*;

  word_t imm_sext;   // Immediate, sign extended to a word
  word_t imm_hi;     // Immediate placed in bits 31..16
  word_t first_lvl;  // Output of the first select stage

  assign imm_sext = {{(WORD_W - IMM_W){imm[IMM_W-1]}}, imm};
  assign imm_hi   = {imm, {(WORD_W - IMM_W){1'b0}}};

  // Two chained 2:1 stages make the 3:1 word select
  // Code 3 matches neither stage and falls through to rt_data
  assign first_lvl = (b_sel == B_IMM_SEXT) ? imm_sext : rt_data;
  assign b_operand = (b_sel == B_IMM_HI) ? imm_hi : first_lvl;

endmodule

//--- hw/reg_file.sv
// Register file of 32 words, two combinational read ports and one write port, r0 fixed at zero
`timescale 1ns/100ps

module reg_file (
  input  logic                     clk,
  input  logic                     rst_n,
  input  cpu_types_pkg::reg_addr_t rs_addr,
  input  cpu_types_pkg::reg_addr_t rt_addr,
  output cpu_types_pkg::word_t     rs_data,
  output cpu_types_pkg::word_t     rt_data,
  input  logic                     wr_en,
  input  cpu_types_pkg::reg_addr_t wr_addr,
  input  cpu_types_pkg::word_t     wr_data
);
  import cpu_types_pkg::*;

  word_t regs [NUM_REGS];

  logic wr_ok;  // Write enable with r0 filtered out

  assign wr_ok = wr_en && (wr_addr != '0);

  // Storage, cleared on reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Each read port is a 32:1 word select on the address
  // r0 is never written, so it reads back its reset value of zero
  assign rs_data = regs[rs_addr];
  assign rt_data = regs[rt_addr];

endmodule

//--- hw/exec_ctrl_pkg.sv
// Control-side types for the execute unit: command, ALU flags and FSM states
package exec_ctrl_pkg;

  // One command as presented on the strobe
  typedef struct packed {
    cpu_types_pkg::alu_op_t   op;     // ALU operation
    cpu_types_pkg::reg_addr_t rs;     // A operand register
    cpu_types_pkg::reg_addr_t rt;     // B operand register
    cpu_types_pkg::reg_addr_t rd;     // Destination
    cpu_types_pkg::imm_t      imm;
    cpu_types_pkg::b_sel_t    b_sel;  // B operand source
  } exec_cmd_t;

  // Status bits produced alongside the ALU result
  typedef struct packed {
    logic zero;
    logic carry;      // Carry out on add, no-borrow on sub
    logic overflow;   // Signed overflow on add and sub
  } alu_flags_t;

  // Control states
  // ST_IDLE waits for a strobe, ST_EXEC reads, computes and writes back
  typedef enum logic {
    ST_IDLE,
    ST_EXEC
  } exec_state_t;

endpackage

//--- hw/cpu_types_pkg.sv
// Data-side types for the execute unit: word widths, register numbers and operation codes
package cpu_types_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int IMM_W      = 16;
  localparam int NUM_REGS   = 32;  // Must cover every reg_addr_t value

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [IMM_W-1:0]      imm_t;

  // ALU operation codes, laid out for the 5:1 result select
  // Bit 0 picks within a pair, bit 1 picks the pair, bit 2 picks slt
  typedef logic [2:0] alu_op_t;

  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_SLT = 3'd4;

  // B operand sources
  typedef logic [1:0] b_sel_t;

  localparam b_sel_t B_REG      = 2'd0;  // Second source register
  localparam b_sel_t B_IMM_SEXT = 2'd1;  // Sign-extended immediate
  localparam b_sel_t B_IMM_HI   = 2'd2;  // Immediate in the upper half

endpackage
